// File: files.f
source/sort_pkg.sv
source/apb_pkg.sv
source/mem_port_if.sv
source/shared_record_ram.sv
source/sort_regs.sv
source/run_fetcher.sv
source/merge_control.sv
source/sorter_top.sv
tb/tb_sorter.sv

// File: run.sh
#!/bin/sh
# build and run the sorter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sorter -f files.f -o sim_sorter
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_sorter > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -q "All tests passed" sim.log; then
  exit 0
fi
exit 1

// File: tb/tb_sorter.sv
module tb_sorter import sort_pkg::*; import apb_pkg::*; ();

  localparam int APB_TIMEOUT  = 200;
  localparam int POLL_TIMEOUT = 1000;

  logic   CLK;
  logic   rst;
  logic   psel;
  logic   penable;
  logic   pwrite;
  paddr_t paddr;
  pdata_t pwdata;
  pdata_t prdata;
  logic   pready;
  logic   pslverr;

  logic [31:0] rng_state = 32'd39;
  int          errors = 0;
  key_t        load_keys [MAX_COUNT];
  key_t        sorted_keys [MAX_COUNT];
  key_t        written [MEM_DEPTH];
  logic        used [MEM_DEPTH];

  sorter_top i_sorter_top (
    .CLK, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // ##################################################
  // failure handling and compare tasks
  // ##################################################
  task automatic abort_run();
    errors++;
    $display("Some tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_data(input string name, input pdata_t got, input pdata_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_key(input string name, input key_t got, input key_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_pass(input string name, input pass_t got, input pass_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // ##################################################
  // APB master
  // ##################################################
  task automatic apb_access(input logic wr, input paddr_t addr, input pdata_t wdata,
                            output pdata_t rdata, output logic err);
    int waited;
    waited = 0;
    @(posedge CLK);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge CLK);
    penable <= 1'b1;
    @(negedge CLK);
    while (!pready) begin
      waited++;
      if (waited > APB_TIMEOUT) begin
        $display("Timeout: APB access to address %h never got pready", addr);
        abort_run();
      end
      @(negedge CLK);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input paddr_t addr, input pdata_t data, input logic exp_err);
    pdata_t unused;
    logic   err;
    apb_access(1'b1, addr, data, unused, err);
    check_flag($sformatf("pslverr on write to %h", addr), err, exp_err);
  endtask

  task automatic apb_read(input paddr_t addr, output pdata_t data, input logic exp_err);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check_flag($sformatf("pslverr on read of %h", addr), err, exp_err);
  endtask

  function automatic paddr_t window_addr(input mem_addr_t addr);
    return MEM_WINDOW_BASE + paddr_t'({addr, 2'b00});
  endfunction

  task automatic write_record(input mem_addr_t addr, input key_t key);
    apb_write(window_addr(addr), pdata_t'(key), 1'b0);
  endtask

  task automatic read_record(input mem_addr_t addr, output key_t key);
    pdata_t rd;
    apb_read(window_addr(addr), rd, 1'b0);
    key = key_t'(rd);
  endtask

  // ##################################################
  // reference model and sort sequencing
  // ##################################################
  task automatic sort_model(input int n);
    key_t tmp;
    int   j;
    for (int i = 0; i < n; i++) begin
      sorted_keys[i] = load_keys[i];
    end
    // insertion sort keeps equal keys in order
    for (int i = 1; i < n; i++) begin
      tmp = sorted_keys[i];
      j = i - 1;
      while (j >= 0 && sorted_keys[j] > tmp) begin
        sorted_keys[j+1] = sorted_keys[j];
        j--;
      end
      sorted_keys[j+1] = tmp;
    end
  endtask

  // one region in each half, order picked at random
  task automatic pick_regions(input int n, output mem_addr_t a, output mem_addr_t b);
    mem_addr_t low;
    mem_addr_t high;
    low  = mem_addr_t'(next_random() % (33 - n));
    high = mem_addr_t'(32 + next_random() % (33 - n));
    if (next_random() & 32'd1) begin
      a = high;
      b = low;
    end else begin
      a = low;
      b = high;
    end
  endtask

  // key_range 0 means full 16 bit keys
  task automatic load_run(input mem_addr_t src, input mem_addr_t dst, input int n,
                          input int key_range);
    for (int i = 0; i < n; i++) begin
      if (key_range == 0) begin
        load_keys[i] = key_t'(next_random());
      end else begin
        load_keys[i] = key_t'(next_random() % key_range);
      end
      write_record(src + mem_addr_t'(i), load_keys[i]);
    end
    sort_model(n);
    apb_write(REG_SRC, pdata_t'(src), 1'b0);
    apb_write(REG_DST, pdata_t'(dst), 1'b0);
    apb_write(REG_COUNT, pdata_t'(n), 1'b0);
  endtask

  task automatic check_result(input mem_addr_t src, input mem_addr_t dst, input int log2n);
    pdata_t    rd;
    int        polls;
    mem_addr_t res;
    key_t      key;
    polls = 0;
    apb_read(REG_STATUS, rd, 1'b0);
    while (!rd[STAT_DONE]) begin
      polls++;
      if (polls > POLL_TIMEOUT) begin
        $display("Timeout: sort of %0d records never reported done", 1 << log2n);
        abort_run();
      end
      apb_read(REG_STATUS, rd, 1'b0);
    end
    check_flag("status busy", rd[STAT_BUSY], 1'b0);
    check_pass("status passes", rd[STAT_PASS_LSB +: $bits(pass_t)], pass_t'(log2n));
    check_flag("status result region", rd[STAT_RESULT], log2n[0]);
    // odd pass count leaves the result in dst
    res = log2n[0] ? dst : src;
    for (int i = 0; i < (1 << log2n); i++) begin
      read_record(res + mem_addr_t'(i), key);
      check_key($sformatf("sorted record %0d", i), key, sorted_keys[i]);
    end
  endtask

  // poll until the running sort has finished its first pass
  task automatic wait_first_pass(output pdata_t status);
    int polls;
    polls = 0;
    apb_read(REG_STATUS, status, 1'b0);
    while (status[STAT_PASS_LSB +: $bits(pass_t)] == '0) begin
      polls++;
      if (polls > POLL_TIMEOUT) begin
        $display("Timeout: running sort never finished its first pass");
        abort_run();
      end
      apb_read(REG_STATUS, status, 1'b0);
    end
  endtask

  task automatic random_sorts(input int rounds, input int key_range);
    mem_addr_t src;
    mem_addr_t dst;
    int        log2n;
    for (int r = 0; r < rounds; r++) begin
      log2n = 1 + int'(next_random() % 5);
      pick_regions(1 << log2n, src, dst);
      load_run(src, dst, 1 << log2n, key_range);
      apb_write(REG_CTRL, 32'd1, 1'b0);
      check_result(src, dst, log2n);
    end
  endtask

  // ##################################################
  // main sequence
  // ##################################################
  initial begin
    pdata_t    rd;
    pdata_t    val;
    key_t      key;
    key_t      guard;
    mem_addr_t addr;
    rst     <= 1'b1;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    repeat (4) @(posedge CLK);
    rst <= 1'b0;

    // idle status and register readback
    apb_read(REG_STATUS, rd, 1'b0);
    check_data("STATUS after reset", rd, '0);
    for (int i = 0; i < 4; i++) begin
      val = next_random();
      apb_write(REG_SRC, val, 1'b0);
      apb_read(REG_SRC, rd, 1'b0);
      check_data("SRC", rd, pdata_t'(mem_addr_t'(val)));
      val = next_random();
      apb_write(REG_DST, val, 1'b0);
      apb_read(REG_DST, rd, 1'b0);
      check_data("DST", rd, pdata_t'(mem_addr_t'(val)));
      val = next_random();
      apb_write(REG_COUNT, val, 1'b0);
      apb_read(REG_COUNT, rd, 1'b0);
      check_data("COUNT", rd, pdata_t'(count_t'(val)));
    end

    // memory window at random addresses
    for (int i = 0; i < MEM_DEPTH; i++) begin
      used[i] = 1'b0;
    end
    for (int i = 0; i < 24; i++) begin
      addr = mem_addr_t'(next_random());
      key  = key_t'(next_random());
      written[addr] = key;
      used[addr]    = 1'b1;
      write_record(addr, key);
    end
    for (int i = 0; i < MEM_DEPTH; i++) begin
      if (used[i]) begin
        read_record(mem_addr_t'(i), key);
        check_key($sformatf("window record %0d", i), key, written[i]);
      end
    end

    random_sorts(10, 0);
    // narrow key range for many ties
    random_sorts(10, 4);

    // accesses while a sort runs
    guard = key_t'(next_random());
    write_record(mem_addr_t'(20), guard);
    load_run(mem_addr_t'(0), mem_addr_t'(32), 16, 0);
    apb_write(REG_CTRL, 32'd1, 1'b0);
    wait_first_pass(rd);
    check_flag("status busy during sort", rd[STAT_BUSY], 1'b1);
    apb_read(window_addr(mem_addr_t'(20)), rd, 1'b1);
    apb_write(window_addr(mem_addr_t'(20)), pdata_t'(~guard), 1'b1);
    apb_write(REG_CTRL, 32'd1, 1'b0);
    // a restart would have cleared the pass count
    apb_read(REG_STATUS, rd, 1'b0);
    check_flag("status passes nonzero after second start",
               rd[STAT_PASS_LSB +: $bits(pass_t)] != '0, 1'b1);
    apb_read(12'h020, rd, 1'b1);
    apb_write(12'h200, 32'd0, 1'b1);
    check_result(mem_addr_t'(0), mem_addr_t'(32), 4);
    read_record(mem_addr_t'(20), key);
    check_key("record 20 after blocked write", key, guard);

    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: source/sorter_top.sv
module sorter_top import sort_pkg::*; import apb_pkg::*; (
  input  logic   CLK,
  input  logic   rst,
  input  logic   psel,
  input  logic   penable,
  input  logic   pwrite,
  input  paddr_t paddr,
  input  pdata_t pwdata,
  output pdata_t prdata,
  output logic   pready,
  output logic   pslverr
);

  logic      go;
  mem_addr_t src;
  mem_addr_t dst;
  count_t    count;
  logic      busy;
  logic      done;
  pass_t     passes;
  logic      fetch_start0;
  logic      fetch_start1;
  mem_addr_t base0;
  mem_addr_t base1;
  count_t    run_len;
  key_t      head0;
  key_t      head1;
  logic      head_valid0;
  logic      head_valid1;
  logic      pop0;
  logic      pop1;

  // one memory port per arbiter slot
  mem_port_if mem_bus [NUM_PEERS] ();

  sort_regs i_sort_regs (
    .CLK, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .mem    (mem_bus[PEER_REGS]),
    .go, .src, .dst, .count, .busy, .done, .passes
  );

  merge_control i_merge_control (
    .CLK, .rst, .go, .src, .dst, .count,
    .writer (mem_bus[PEER_WRITER]),
    .fetch_start0, .fetch_start1, .base0, .base1, .run_len,
    .head0, .head1, .head_valid0, .head_valid1, .pop0, .pop1,
    .busy, .done, .passes
  );

  run_fetcher i_fetch0 (
    .CLK, .rst,
    .start      (fetch_start0),
    .base       (base0),
    .len        (run_len),
    .mem        (mem_bus[PEER_FETCH0]),
    .head       (head0),
    .head_valid (head_valid0),
    .pop        (pop0)
  );

  run_fetcher i_fetch1 (
    .CLK, .rst,
    .start      (fetch_start1),
    .base       (base1),
    .len        (run_len),
    .mem        (mem_bus[PEER_FETCH1]),
    .head       (head1),
    .head_valid (head_valid1),
    .pop        (pop1)
  );

  shared_record_ram i_shared_record_ram (
    .CLK, .rst,
    .regs_port   (mem_bus[PEER_REGS]),
    .fetch0_port (mem_bus[PEER_FETCH0]),
    .fetch1_port (mem_bus[PEER_FETCH1]),
    .writer_port (mem_bus[PEER_WRITER])
  );

endmodule

// File: source/merge_control.sv
module merge_control import sort_pkg::*; (
  input  logic      CLK,
  input  logic      rst,
  input  logic      go,
  input  mem_addr_t src,
  input  mem_addr_t dst,
  input  count_t    count,
  mem_port_if.requester writer,
  output logic      fetch_start0,
  output logic      fetch_start1,
  output mem_addr_t base0,
  output mem_addr_t base1,
  output count_t    run_len,
  input  key_t      head0,
  input  key_t      head1,
  input  logic      head_valid0,
  input  logic      head_valid1,
  output logic      pop0,
  output logic      pop1,
  output logic      busy,
  output logic      done,
  output pass_t     passes
);

  typedef enum logic [2:0] {
    idle,
    start_pair,
    merge,
    next_pair,
    next_pass
  } state_t;

  state_t    state;
  count_t    width;
  count_t    width_x2;
  count_t    out_off;
  count_t    rem0;
  count_t    rem1;
  mem_addr_t rd_base;
  mem_addr_t wr_base;
  logic      take0;
  logic      take1;

  // ping-pong, even passes read src
  assign rd_base  = passes[0] ? dst : src;
  assign wr_base  = passes[0] ? src : dst;
  assign width_x2 = width << 1;

  // ##################################################
  // run pair fetch
  // ##################################################
  assign fetch_start0 = (state == start_pair);
  assign fetch_start1 = (state == start_pair);
  assign base0        = rd_base + mem_addr_t'(out_off);
  assign base1        = base0 + mem_addr_t'(width);
  assign run_len      = width;

  // ##################################################
  // head compare and output write
  // ##################################################
  // a side with nothing left lets the other drain; ties go to run 0
  assign take0 = head_valid0 && (rem1 == '0 || (head_valid1 && head0 <= head1));
  assign take1 = head_valid1 && (rem0 == '0 || (head_valid0 && head1 < head0));

  assign writer.req   = (state == merge) && (take0 || take1);
  assign writer.we    = 1'b1;
  assign writer.addr  = wr_base + mem_addr_t'(out_off);
  assign writer.wdata = take0 ? head0 : head1;

  // pop only when the write is accepted
  assign pop0 = writer.gnt && take0;
  assign pop1 = writer.gnt && take1;

  always_ff @(posedge CLK) begin
    if (rst) begin
      state   <= idle;
      busy    <= 1'b0;
      done    <= 1'b0;
      passes  <= '0;
      width   <= '0;
      out_off <= '0;
      rem0    <= '0;
      rem1    <= '0;
    end else begin
      case (state)
        idle: begin
          if (go) begin
            busy    <= 1'b1;
            done    <= 1'b0;
            passes  <= '0;
            width   <= count_t'(1);
            out_off <= '0;
            state   <= start_pair;
          end
        end
        start_pair: begin
          rem0  <= width;
          rem1  <= width;
          state <= merge;
        end
        merge: begin
          if (writer.gnt) begin
            out_off <= out_off + 1'b1;
          end
          rem0 <= rem0 - count_t'(pop0);
          rem1 <= rem1 - count_t'(pop1);
          if (rem0 == '0 && rem1 == '0) begin
            state <= next_pair;
          end
        end
        next_pair: begin
          state <= (out_off == count) ? next_pass : start_pair;
        end
        next_pass: begin
          passes  <= passes + 1'b1;
          out_off <= '0;
          width   <= width_x2;
          // last pass once runs span the whole set
          if (width_x2 == count) begin
            busy  <= 1'b0;
            done  <= 1'b1;
            state <= idle;
          end else begin
            state <= start_pair;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

// File: source/run_fetcher.sv
module run_fetcher import sort_pkg::*; (
  input  logic      CLK,
  input  logic      rst,
  input  logic      start,
  input  mem_addr_t base,
  input  count_t    len,
  mem_port_if.requester mem,
  output key_t      head,
  output logic      head_valid,
  input  logic      pop
);

  key_t       slot [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] reserved;
  logic [1:0] filled;
  mem_addr_t  next_addr;
  count_t     to_issue;

  // a slot is reserved when the read is granted
  assign mem.req   = (to_issue != '0) && (reserved != 2'd2);
  assign mem.we    = 1'b0;
  assign mem.addr  = next_addr;
  assign mem.wdata = '0;

  assign head       = slot[rd_ptr];
  assign head_valid = (filled != 2'd0);

  always_ff @(posedge CLK) begin
    if (rst) begin
      to_issue  <= '0;
      next_addr <= '0;
      reserved  <= '0;
      filled    <= '0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
    end else if (start) begin
      to_issue  <= len;
      next_addr <= base;
      reserved  <= '0;
      filled    <= '0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
    end else begin
      if (mem.gnt) begin
        next_addr <= next_addr + 1'b1;
        to_issue  <= to_issue - 1'b1;
      end
      reserved <= reserved + 2'(mem.gnt) - 2'(pop);
      filled   <= filled + 2'(mem.rvalid) - 2'(pop);
      if (mem.rvalid) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
    end
  end

  // returns come back in request order
  always_ff @(posedge CLK) begin
    if (mem.rvalid) begin
      slot[wr_ptr] <= mem.rdata;
    end
  end

endmodule

// File: source/sort_regs.sv
module sort_regs import sort_pkg::*; import apb_pkg::*; (
  input  logic       CLK,
  input  logic       rst,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  paddr_t     paddr,
  input  pdata_t     pwdata,
  output pdata_t     prdata,
  output logic       pready,
  output logic       pslverr,
  mem_port_if.requester mem,
  output logic       go,
  output mem_addr_t  src,
  output mem_addr_t  dst,
  output count_t     count,
  input  logic       busy,
  input  logic       done,
  input  pass_t      passes
);

  logic   access;
  logic   is_win;
  logic   reg_hit;
  paddr_t win_off;
  logic   rd_wait;
  pdata_t status;

  assign access  = psel && penable;
  assign win_off = paddr - MEM_WINDOW_BASE;
  assign is_win  = (paddr >= MEM_WINDOW_BASE) && (win_off < paddr_t'(MEM_DEPTH * 4));
  assign reg_hit = paddr inside {REG_CTRL, REG_STATUS, REG_SRC, REG_DST, REG_COUNT};

  // start only from idle
  assign go = access && pwrite && (paddr == REG_CTRL) && pwdata[0] && !busy;

  // ##################################################
  // memory window
  // ##################################################
  assign mem.req   = access && is_win && !busy && !rd_wait;
  assign mem.we    = pwrite;
  assign mem.addr  = mem_addr_t'(win_off >> 2);
  assign mem.wdata = key_t'(pwdata);

  // writes end on grant, reads on rvalid
  assign pready  = access && (!is_win || busy || (pwrite ? mem.gnt : mem.rvalid));
  assign pslverr = access && ((!is_win && !reg_hit) || (is_win && busy));

  always_comb begin
    status                                 = '0;
    status[STAT_BUSY]                      = busy;
    status[STAT_DONE]                      = done;
    status[STAT_RESULT]                    = passes[0];
    status[STAT_PASS_LSB +: $bits(pass_t)] = passes;
    if (is_win) begin
      prdata = pdata_t'(mem.rdata);
    end else begin
      case (paddr)
        REG_STATUS: prdata = status;
        REG_SRC:    prdata = pdata_t'(src);
        REG_DST:    prdata = pdata_t'(dst);
        REG_COUNT:  prdata = pdata_t'(count);
        default:    prdata = '0;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      src     <= '0;
      dst     <= '0;
      count   <= '0;
      rd_wait <= 1'b0;
    end else begin
      if (access && pwrite) begin
        case (paddr)
          REG_SRC:   src   <= mem_addr_t'(pwdata);
          REG_DST:   dst   <= mem_addr_t'(pwdata);
          REG_COUNT: count <= count_t'(pwdata);
          default: ;
        endcase
      end
      // hold off the request until read data is back
      if (mem.gnt && !mem.we) begin
        rd_wait <= 1'b1;
      end else if (mem.rvalid) begin
        rd_wait <= 1'b0;
      end
    end
  end

endmodule

// File: source/shared_record_ram.sv
module shared_record_ram import sort_pkg::*; (
  input  logic       CLK,
  input  logic       rst,
  mem_port_if.arbiter regs_port,
  mem_port_if.arbiter fetch0_port,
  mem_port_if.arbiter fetch1_port,
  mem_port_if.arbiter writer_port
);

  logic [NUM_PEERS-1:0] req_vec;
  logic [NUM_PEERS-1:0] we_vec;
  mem_addr_t            addr_vec [NUM_PEERS];
  key_t                 wdata_vec [NUM_PEERS];
  logic [NUM_PEERS-1:0] gnt_vec;
  logic [NUM_PEERS-1:0] rvalid_vec;
  peer_t                last_peer;
  peer_t                sel_peer;
  logic                 any_gnt;
  key_t                 ram [MEM_DEPTH];
  key_t                 rd_data;

  // gather requesters by slot
  assign req_vec[PEER_REGS]     = regs_port.req;
  assign req_vec[PEER_FETCH0]   = fetch0_port.req;
  assign req_vec[PEER_FETCH1]   = fetch1_port.req;
  assign req_vec[PEER_WRITER]   = writer_port.req;
  assign we_vec[PEER_REGS]      = regs_port.we;
  assign we_vec[PEER_FETCH0]    = fetch0_port.we;
  assign we_vec[PEER_FETCH1]    = fetch1_port.we;
  assign we_vec[PEER_WRITER]    = writer_port.we;
  assign addr_vec[PEER_REGS]    = regs_port.addr;
  assign addr_vec[PEER_FETCH0]  = fetch0_port.addr;
  assign addr_vec[PEER_FETCH1]  = fetch1_port.addr;
  assign addr_vec[PEER_WRITER]  = writer_port.addr;
  assign wdata_vec[PEER_REGS]   = regs_port.wdata;
  assign wdata_vec[PEER_FETCH0] = fetch0_port.wdata;
  assign wdata_vec[PEER_FETCH1] = fetch1_port.wdata;
  assign wdata_vec[PEER_WRITER] = writer_port.wdata;

  assign regs_port.gnt   = gnt_vec[PEER_REGS];
  assign fetch0_port.gnt = gnt_vec[PEER_FETCH0];
  assign fetch1_port.gnt = gnt_vec[PEER_FETCH1];
  assign writer_port.gnt = gnt_vec[PEER_WRITER];

  // read data is shared, rvalid tells who owns it
  assign regs_port.rdata     = rd_data;
  assign fetch0_port.rdata   = rd_data;
  assign fetch1_port.rdata   = rd_data;
  assign writer_port.rdata   = rd_data;
  assign regs_port.rvalid    = rvalid_vec[PEER_REGS];
  assign fetch0_port.rvalid  = rvalid_vec[PEER_FETCH0];
  assign fetch1_port.rvalid  = rvalid_vec[PEER_FETCH1];
  assign writer_port.rvalid  = rvalid_vec[PEER_WRITER];

  // ##################################################
  // round robin, search starts after last winner
  // ##################################################
  always_comb begin
    peer_t cand;
    any_gnt  = 1'b0;
    sel_peer = last_peer;
    gnt_vec  = '0;
    for (int i = 1; i <= NUM_PEERS; i++) begin
      cand = last_peer + peer_t'(i);
      if (!any_gnt && req_vec[cand]) begin
        any_gnt  = 1'b1;
        sel_peer = cand;
      end
    end
    if (any_gnt) begin
      gnt_vec[sel_peer] = 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      last_peer  <= PEER_WRITER;
      rvalid_vec <= '0;
    end else begin
      rvalid_vec <= '0;
      if (any_gnt) begin
        last_peer            <= sel_peer;
        rvalid_vec[sel_peer] <= !we_vec[sel_peer];
      end
    end
  end

  // single port array, one access per grant
  always_ff @(posedge CLK) begin
    if (any_gnt) begin
      if (we_vec[sel_peer]) begin
        ram[addr_vec[sel_peer]] <= wdata_vec[sel_peer];
      end else begin
        rd_data <= ram[addr_vec[sel_peer]];
      end
    end
  end

endmodule

// File: source/mem_port_if.sv
interface mem_port_if import sort_pkg::*; ();

  // request side
  logic      req;
  logic      we;
  mem_addr_t addr;
  key_t      wdata;

  // response side
  logic      gnt;
  key_t      rdata;
  logic      rvalid;

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata, rvalid
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata, rvalid
  );

endinterface

// File: source/apb_pkg.sv
package apb_pkg;

  localparam int APB_ADDR_W = 12;
  localparam int APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] paddr_t;
  typedef logic [APB_DATA_W-1:0] pdata_t;

  // ##################################################
  // register map
  // ##################################################
  localparam paddr_t REG_CTRL        = 12'h000;
  localparam paddr_t REG_STATUS      = 12'h004;
  localparam paddr_t REG_SRC         = 12'h008;
  localparam paddr_t REG_DST         = 12'h00C;
  localparam paddr_t REG_COUNT       = 12'h010;
  localparam paddr_t MEM_WINDOW_BASE = 12'h100;

  // status fields
  localparam int STAT_BUSY     = 0;
  localparam int STAT_DONE     = 1;
  localparam int STAT_RESULT   = 2;
  localparam int STAT_PASS_LSB = 8;

endpackage

// File: source/sort_pkg.sv
package sort_pkg;

  // ##################################################
  // record memory sizing
  // ##################################################
  localparam int MEM_DEPTH = 64;
  localparam int MAX_COUNT = 32;
  localparam int NUM_PEERS = 4;

  // one record is a bare key
  typedef logic [15:0] key_t;

  typedef logic [$clog2(MEM_DEPTH)-1:0] mem_addr_t;

  // must hold MAX_COUNT itself
  typedef logic [$clog2(MAX_COUNT+1)-1:0] count_t;

  // up to log2(MAX_COUNT) passes
  typedef logic [$clog2($clog2(MAX_COUNT)+1)-1:0] pass_t;

  typedef logic [$clog2(NUM_PEERS)-1:0] peer_t;

  // fixed arbiter slots
  localparam peer_t PEER_REGS   = 2'd0;
  localparam peer_t PEER_FETCH0 = 2'd1;
  localparam peer_t PEER_FETCH1 = 2'd2;
  localparam peer_t PEER_WRITER = 2'd3;

endpackage
